//--- verilog/elinkCanPkg.sv
package elinkCanPkg;

   // elink frame layout
   // bytes per valid frame, the two header bytes included
   localparam int FRAME_LEN = 12;
   // header bytes ahead of the buffer positions
   localparam int HDR_LEN = 2;
   // message buffer bytes, frame positions 2 to 11
   localparam int MSG_BYTES = 10;
   // required value of frame byte 1
   localparam logic [7:0] FRAME_TYPE_CAN = 8'hA5;
   // width of the buffer address and the position counter
   localparam int ADDR_W = 5;

   // message queue and flow control
   localparam int QUEUE_DEPTH = 4;
   // credits granted by the consumer at reset
   localparam int CREDIT_INIT = 2;
   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   // occupancy has to reach QUEUE_DEPTH itself
   localparam int OCC_W = $clog2(QUEUE_DEPTH + 1);
   localparam int CRD_W = $clog2(CREDIT_INIT + 1);

   // error and drop counters, saturating at all ones
   localparam int CNT_W = 8;

   // one symbol slot from the elink deserializer
   typedef struct packed {
      logic [7:0] data;
      // slot carries a byte
      logic       valid;
      // first byte of a frame
      logic       sof;
      // last byte of a frame
      logic       eof;
   } elinkByte_t;

   // completed CAN message, 76 bits
   typedef struct packed {
      // buffer byte 0
      logic [7:0]  busSel;
      // buffer bytes 1 and 2, byte 1 on top
      logic [15:0] cobId;
      // buffer bytes 3 to 8, byte 3 on top
      logic [47:0] payload;
      // upper nibble of buffer byte 9
      logic [3:0]  dlc;
   } canMsg_t;

endpackage

//--- verilog/elinkFrameRx.sv
`timescale 1ns/1ns

module elinkFrameRx
(
   input  logic                             clk,
   input  logic                             rst,
   input  elinkCanPkg::elinkByte_t          rxByte,
   output logic                             wrEn,
   output logic [elinkCanPkg::ADDR_W-1:0]   addr,
   output logic [7:0]                       wrData,
   output logic                             commit,
   output logic [elinkCanPkg::CNT_W-1:0]    frameErrCount
);

   // next expected frame position
   logic [elinkCanPkg::ADDR_W-1:0] posCnt;
   // a sof has been seen and no eof yet
   logic                           inFrame;
   // byte 1 of the current frame matched the CAN type
   logic                           typeOk;
   // eof of a good frame, one cycle ahead of commit
   logic                           commitReq;

   // position and state as seen by the byte on the input this cycle
   logic [elinkCanPkg::ADDR_W-1:0] curPos;
   logic                           curInFrame;
   logic                           inWindow;
   logic                           doWrite;
   logic                           endOfFrame;
   logic                           frameGood;

   always_comb
   begin
      // sof restarts counting, even in the middle of a frame
      curPos     = rxByte.sof ? '0 : posCnt;
      curInFrame = rxByte.sof | inFrame;
      // positions 2 to 11 map onto the buffer
      inWindow   = (curPos >= elinkCanPkg::ADDR_W'(elinkCanPkg::HDR_LEN)) &&
                   (curPos <= elinkCanPkg::ADDR_W'(elinkCanPkg::FRAME_LEN - 1));
      // typeOk is stale only at position 0, which is outside the window
      doWrite    = rxByte.valid && curInFrame && typeOk && inWindow;
      endOfFrame = rxByte.valid && rxByte.eof;
      // eof must land exactly on the last position of a typed frame
      frameGood  = curInFrame && typeOk &&
                   (curPos == elinkCanPkg::ADDR_W'(elinkCanPkg::FRAME_LEN - 1));
   end

   // frame tracking
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         posCnt  <= '0;
         inFrame <= 1'b0;
         typeOk  <= 1'b0;
      end
      else if (rxByte.valid)
      begin
         if (rxByte.eof)
         begin
            // ready for the next frame
            posCnt  <= '0;
            inFrame <= 1'b0;
         end
         else
         begin
            // saturate so long frames never wrap back into the window
            if (curPos != '1)
            begin
               posCnt <= curPos + 1'b1;
            end
            else
            begin
               posCnt <= curPos;
            end
            inFrame <= curInFrame;
         end
         // type byte decides the rest of the frame
         if (rxByte.sof)
         begin
            typeOk <= 1'b0;
         end
         else if (curPos == elinkCanPkg::ADDR_W'(1))
         begin
            typeOk <= (rxByte.data == elinkCanPkg::FRAME_TYPE_CAN);
         end
      end
   end

   // write strobe, commit pipeline and error count
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wrEn          <= 1'b0;
         commitReq     <= 1'b0;
         commit        <= 1'b0;
         frameErrCount <= '0;
      end
      else
      begin
         wrEn      <= doWrite;
         commitReq <= endOfFrame && frameGood;
         // commit follows the eof byte's write by one cycle
         commit    <= commitReq;
         // short, long, untyped or sof-less frames all land here
         if (endOfFrame && !frameGood && (frameErrCount != '1))
         begin
            frameErrCount <= frameErrCount + 1'b1;
         end
      end
   end

   // address and data only matter while wrEn is high
   always_ff @(posedge clk)
   begin
      if (doWrite)
      begin
         addr   <= curPos;
         wrData <= rxByte.data;
      end
   end

endmodule

//--- verilog/canMsgBuffer.sv
`timescale 1ns/1ns

module canMsgBuffer
(
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             wrEn,
   input  logic [elinkCanPkg::ADDR_W-1:0]   addr,
   input  logic [7:0]                       wrData,
   input  logic                             commit,
   output elinkCanPkg::canMsg_t             msg,
   output logic                             push
);

   // message bytes, buffer byte 0 sits at frame position 2
   logic [7:0] msgBytes  [elinkCanPkg::MSG_BYTES];
   // bytes with this cycle's write already applied
   logic [7:0] nextBytes [elinkCanPkg::MSG_BYTES];
   logic [elinkCanPkg::ADDR_W-1:0] idx;
   logic                           hit;
   elinkCanPkg::canMsg_t           packMsg;

   always_comb
   begin
      idx = addr - elinkCanPkg::ADDR_W'(elinkCanPkg::HDR_LEN);
      // header positions and anything past 11 are ignored
      hit = wrEn &&
            (addr >= elinkCanPkg::ADDR_W'(elinkCanPkg::HDR_LEN)) &&
            (addr < elinkCanPkg::ADDR_W'(elinkCanPkg::HDR_LEN + elinkCanPkg::MSG_BYTES));
      for (int i = 0; i < elinkCanPkg::MSG_BYTES; i++)
      begin
         if (hit && (idx == elinkCanPkg::ADDR_W'(i)))
         begin
            nextBytes[i] = wrData;
         end
         else
         begin
            nextBytes[i] = msgBytes[i];
         end
      end
   end

   // packing order of the CAN message
   always_comb
   begin
      packMsg.busSel  = nextBytes[0];
      packMsg.cobId   = {nextBytes[1], nextBytes[2]};
      packMsg.payload = {nextBytes[3], nextBytes[4], nextBytes[5],
                         nextBytes[6], nextBytes[7], nextBytes[8]};
      // low nibble of byte 9 carries nothing
      packMsg.dlc     = nextBytes[9][7:4];
   end

   // byte storage
   always_ff @(posedge clk)
   begin
      msgBytes <= nextBytes;
   end

   // message snapshot, valid only alongside push
   always_ff @(posedge clk)
   begin
      if (commit)
      begin
         msg <= packMsg;
      end
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         push <= 1'b0;
      end
      else
      begin
         push <= commit;
      end
   end

endmodule

//--- verilog/canMsgQueue.sv
`timescale 1ns/1ns

module canMsgQueue
(
   input  logic                             clk,
   input  logic                             rst,
   input  elinkCanPkg::canMsg_t             msg,
   input  logic                             push,
   input  logic                             creditReturn,
   output elinkCanPkg::canMsg_t             msgOut,
   output logic                             msgValid,
   output logic [elinkCanPkg::CNT_W-1:0]    dropCount
);

   // circular message store
   elinkCanPkg::canMsg_t           mem [elinkCanPkg::QUEUE_DEPTH];
   logic [elinkCanPkg::PTR_W-1:0]  wrPtr;
   logic [elinkCanPkg::PTR_W-1:0]  rdPtr;
   // stored entries
   logic [elinkCanPkg::OCC_W-1:0]  count;
   // credits currently held from the consumer
   logic [elinkCanPkg::CRD_W-1:0]  credits;

   logic                           empty;
   logic                           full;
   logic                           issue;
   logic                           pushAcc;
   logic                           store;
   logic                           pop;
   logic [elinkCanPkg::CRD_W:0]    creditSum;
   elinkCanPkg::canMsg_t           headData;

   always_comb
   begin
      empty     = (count == '0);
      full      = (count == elinkCanPkg::OCC_W'(elinkCanPkg::QUEUE_DEPTH));
      // an empty queue passes the incoming push straight to the output
      headData  = empty ? msg : mem[rdPtr];
      issue     = (credits != '0) && (!empty || push);
      // full means dropped, even if the head leaves this cycle
      pushAcc   = push && !full;
      store     = pushAcc && !(issue && empty);
      pop       = issue && !empty;
      // issue needs a credit, so this never goes below zero
      creditSum = {1'b0, credits} + creditReturn - issue;
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (store)
      begin
         mem[wrPtr] <= msg;
      end
   end

   // pointers, occupancy and credit count
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wrPtr   <= '0;
         rdPtr   <= '0;
         count   <= '0;
         credits <= elinkCanPkg::CRD_W'(elinkCanPkg::CREDIT_INIT);
      end
      else
      begin
         // depth is a power of two, pointers wrap on their own
         if (store)
         begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (pop)
         begin
            rdPtr <= rdPtr + 1'b1;
         end
         count <= count + elinkCanPkg::OCC_W'(store) - elinkCanPkg::OCC_W'(pop);
         // never hold more than the consumer handed out
         if (creditSum > (elinkCanPkg::CRD_W + 1)'(elinkCanPkg::CREDIT_INIT))
         begin
            credits <= elinkCanPkg::CRD_W'(elinkCanPkg::CREDIT_INIT);
         end
         else
         begin
            credits <= creditSum[elinkCanPkg::CRD_W-1:0];
         end
      end
   end

   // output pulse and drop count
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         msgValid  <= 1'b0;
         dropCount <= '0;
      end
      else
      begin
         msgValid <= issue;
         if (push && full && (dropCount != '1))
         begin
            dropCount <= dropCount + 1'b1;
         end
      end
   end

   // output message register, qualified by msgValid
   always_ff @(posedge clk)
   begin
      if (issue)
      begin
         msgOut <= headData;
      end
   end

endmodule

//--- verilog/elinkCanTop.sv
`timescale 1ns/1ns

module elinkCanTop
(
   input  logic                             clk,
   input  logic                             rst,
   input  elinkCanPkg::elinkByte_t          rxByte,
   input  logic                             creditReturn,
   output elinkCanPkg::canMsg_t             msgOut,
   output logic                             msgValid,
   output logic [elinkCanPkg::CNT_W-1:0]    frameErrCount,
   output logic [elinkCanPkg::CNT_W-1:0]    dropCount
);

   // receiver to buffer
   logic                           wrEn;
   logic [elinkCanPkg::ADDR_W-1:0] addr;
   logic [7:0]                     wrData;
   logic                           commit;
   // buffer to queue
   elinkCanPkg::canMsg_t           bufMsg;
   logic                           push;

   elinkFrameRx i_frameRx (
      .clk           (clk),
      .rst           (rst),
      .rxByte        (rxByte),
      .wrEn          (wrEn),
      .addr          (addr),
      .wrData        (wrData),
      .commit        (commit),
      .frameErrCount (frameErrCount)
   );

   canMsgBuffer i_msgBuffer (
      .clk    (clk),
      .rst    (rst),
      .wrEn   (wrEn),
      .addr   (addr),
      .wrData (wrData),
      .commit (commit),
      .msg    (bufMsg),
      .push   (push)
   );

   // credited queue toward the CAN side
   canMsgQueue i_msgQueue (
      .clk          (clk),
      .rst          (rst),
      .msg          (bufMsg),
      .push         (push),
      .creditReturn (creditReturn),
      .msgOut       (msgOut),
      .msgValid     (msgValid),
      .dropCount    (dropCount)
   );

endmodule

//--- verification/elinkCan_properties.sv
`timescale 1ns/1ns

module elinkCanProperties
(
   input logic                            clk,
   input logic                            rst,
   input logic                            msgValid,
   input logic                            commit,
   input logic [elinkCanPkg::CRD_W-1:0]   credits,
   input logic [elinkCanPkg::OCC_W-1:0]   count
);

   // msgValid is registered, so the credit it used was held one cycle earlier
   aIssueNeedsCredit: assert property (@(posedge clk) disable iff (!rst)
      msgValid |-> ($past(credits) != '0))
      else $error("message issued while no credit was held");

   // returns beyond the outstanding credits are absorbed
   aCreditLimit: assert property (@(posedge clk) disable iff (!rst)
      credits <= elinkCanPkg::CRD_W'(elinkCanPkg::CREDIT_INIT))
      else $error("credit count above the initial grant");

   aOccupancyLimit: assert property (@(posedge clk) disable iff (!rst)
      count <= elinkCanPkg::OCC_W'(elinkCanPkg::QUEUE_DEPTH))
      else $error("queue holds more entries than its depth");

   // one commit per frame, and frames are longer than one byte
   aCommitPulse: assert property (@(posedge clk) disable iff (!rst)
      commit |=> !commit)
      else $error("commit held for two cycles");

endmodule

bind elinkCanTop elinkCanProperties i_props (
   .clk      (clk),
   .rst      (rst),
   .msgValid (msgValid),
   .commit   (commit),
   .credits  (i_msgQueue.credits),
   .count    (i_msgQueue.count)
);

//--- verification/tbElinkCan.sv
`timescale 1ns/1ns

module tbElinkCan;

   localparam int CHK_W = $bits(elinkCanPkg::canMsg_t);
   localparam int FL = elinkCanPkg::FRAME_LEN;
   localparam int RESET_CYC = 16;
   // cycle budget per test, worst-case idle gaps included
   localparam int TEST1_CYC = 60;
   localparam int TEST2_CYC = 4 * (FL + 1 + 8) + 20;
   localparam int TEST3_CYC = 6 * FL * 4 + 6 * 3 + 220;
   localparam int TEST4_CYC = 4 * FL + 100;
   localparam int TEST5_CYC = 7 * FL + 120;
   localparam int MARGIN_CYC = 100;
   localparam int TIMEOUT_CYC = RESET_CYC + TEST1_CYC + TEST2_CYC + TEST3_CYC +
                                TEST4_CYC + TEST5_CYC + MARGIN_CYC;

   logic                          clk;
   logic                          rst;
   elinkCanPkg::elinkByte_t       rxByte;
   logic                          creditReturn;
   elinkCanPkg::canMsg_t          msgOut;
   logic                          msgValid;
   logic [elinkCanPkg::CNT_W-1:0] frameErrCount;
   logic [elinkCanPkg::CNT_W-1:0] dropCount;

   // frame being sent, room for an overlong one
   logic [7:0]           txBytes [16];
   // expected messages, oldest first
   elinkCanPkg::canMsg_t expQ [$];
   int                   errs;
   int                   checks;
   int                   recvCount;
   int                   cycles;
   // credits owed to the DUT and credit pulses already sent
   int                   creditReq;
   int                   creditSent;
   // consumer hands back one credit per message it sees
   bit                   autoCredit;

   elinkCanTop i_dut (
      .clk           (clk),
      .rst           (rst),
      .rxByte        (rxByte),
      .creditReturn  (creditReturn),
      .msgOut        (msgOut),
      .msgValid      (msgValid),
      .frameErrCount (frameErrCount),
      .dropCount     (dropCount)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic checkVal(input logic [CHK_W-1:0] got, input logic [CHK_W-1:0] exp,
                           input string what);
      checks++;
      if (got !== exp)
      begin
         $display("ERR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errs++;
      end
   endtask

   // expected message from the frame bytes, positions 2 to 11
   function automatic elinkCanPkg::canMsg_t expectedMsg();
      elinkCanPkg::canMsg_t m;
      m.busSel  = txBytes[2];
      m.cobId   = {txBytes[3], txBytes[4]};
      m.payload = {txBytes[5], txBytes[6], txBytes[7], txBytes[8], txBytes[9], txBytes[10]};
      // only the upper nibble of the last byte counts
      m.dlc     = txBytes[11][7:4];
      return m;
   endfunction

   // random header and body, correct type byte
   task automatic fillFrame();
      for (int i = 0; i < 16; i++)
      begin
         txBytes[i] = 8'($urandom);
      end
      txBytes[1] = elinkCanPkg::FRAME_TYPE_CAN;
   endtask

   task automatic idle(input int n);
      repeat (n)
      begin
         @(posedge clk);
         rxByte <= '0;
      end
   endtask

   // sends txBytes, eof on the last one; returns right after the eof slot
   task automatic sendBytes(input int len, input bit withSof, input int maxGap);
      elinkCanPkg::elinkByte_t slot;
      int gaps;
      for (int i = 0; i < len; i++)
      begin
         gaps = (i > 0 && maxGap > 0) ? int'($urandom_range(maxGap, 0)) : 0;
         idle(gaps);
         slot.data  = txBytes[i];
         slot.valid = 1'b1;
         slot.sof   = withSof && (i == 0);
         slot.eof   = (i == len - 1);
         @(posedge clk);
         rxByte <= slot;
      end
   endtask

   task automatic sendFrame(input int maxGap, input bit expectOut);
      sendBytes(FL, 1'b1, maxGap);
      if (expectOut)
      begin
         expQ.push_back(expectedMsg());
      end
   endtask

   task automatic waitRecv(input int target, input int limit);
      int n;
      n = 0;
      while (recvCount < target && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (recvCount < target)
      begin
         $display("after %0d cycles only %0d of %0d messages arrived", limit, recvCount, target);
         errs++;
      end
   endtask

   task automatic reportTest(input string name, input int e0);
      if (errs == e0)
      begin
         $display("test %s: pass", name);
      end
      else
      begin
         $display("test %s: fail, %0d errors", name, errs - e0);
      end
   endtask

   // every message against the oldest expected one
   task automatic runMonitor();
      forever
      begin
         @(negedge clk);
         if (rst && msgValid)
         begin
            recvCount++;
            if (autoCredit)
            begin
               creditReq++;
            end
            if (expQ.size() == 0)
            begin
               $display("message at %0t ns arrived with no frame outstanding", $time);
               errs++;
            end
            else
            begin
               checkVal(msgOut, expQ.pop_front(), "msgOut");
            end
         end
      end
   endtask

   // one credit pulse per cycle until the debt is paid
   task automatic driveCredits();
      forever
      begin
         @(posedge clk);
         if (creditSent < creditReq)
         begin
            creditReturn <= 1'b1;
            creditSent++;
         end
         else
         begin
            creditReturn <= 1'b0;
         end
      end
   endtask

   task automatic watchdog();
      while (cycles < TIMEOUT_CYC)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("TB FAILED");
      $finish;
   endtask

   task automatic testSingleFrame();
      int e0;
      int lat;
      bit seen;
      e0 = errs;
      autoCredit = 1'b1;
      fillFrame();
      // low nibble set so a leak into dlc would show
      txBytes[11] = 8'h9C;
      sendFrame(0, 1'b1);
      lat = 0;
      seen = 1'b0;
      while (!seen && lat < 16)
      begin
         @(posedge clk);
         rxByte <= '0;
         lat++;
         @(negedge clk);
         seen = msgValid;
      end
      if (!seen)
      begin
         $display("a valid frame produced no message");
         errs++;
      end
      checkVal(CHK_W'(lat), CHK_W'(4), "eof to msgValid latency");
      checkVal(CHK_W'(msgOut.dlc), CHK_W'(4'h9), "msgOut.dlc");
      idle(4);
      reportTest("single frame", e0);
   endtask

   task automatic testMalformed();
      int e0;
      int r0;
      int errBase;
      e0 = errs;
      r0 = recvCount;
      errBase = int'(frameErrCount);
      // short frame, eof one byte early
      fillFrame();
      sendBytes(FL - 1, 1'b1, 0);
      idle(8);
      checkVal(CHK_W'(frameErrCount), CHK_W'(errBase + 1), "frameErrCount after short frame");
      // long frame, one byte past position 11
      fillFrame();
      sendBytes(FL + 1, 1'b1, 0);
      idle(8);
      checkVal(CHK_W'(frameErrCount), CHK_W'(errBase + 2), "frameErrCount after long frame");
      // right length but no sof
      fillFrame();
      sendBytes(FL, 1'b0, 0);
      idle(8);
      checkVal(CHK_W'(frameErrCount), CHK_W'(errBase + 3), "frameErrCount after missing sof");
      fillFrame();
      txBytes[1] = 8'h3C;
      sendBytes(FL, 1'b1, 0);
      idle(8);
      checkVal(CHK_W'(frameErrCount), CHK_W'(errBase + 4), "frameErrCount after wrong type");
      checkVal(CHK_W'(recvCount), CHK_W'(r0), "messages from malformed frames");
      reportTest("malformed frames", e0);
   endtask

   task automatic testRandomGaps();
      int e0;
      int r0;
      e0 = errs;
      r0 = recvCount;
      autoCredit = 1'b1;
      for (int f = 0; f < 6; f++)
      begin
         fillFrame();
         sendFrame(3, 1'b1);
         idle(int'($urandom_range(3, 0)));
      end
      waitRecv(r0 + 6, 200);
      checkVal(CHK_W'(expQ.size()), CHK_W'(0), "messages still expected");
      reportTest("random gaps", e0);
   endtask

   task automatic testBackPressure();
      int e0;
      int r0;
      e0 = errs;
      // let the last returned credits settle
      idle(4);
      autoCredit = 1'b0;
      r0 = recvCount;
      for (int f = 0; f < 4; f++)
      begin
         fillFrame();
         sendFrame(0, 1'b1);
      end
      idle(20);
      checkVal(CHK_W'(recvCount), CHK_W'(r0 + elinkCanPkg::CREDIT_INIT), "issued on init credits");
      creditReq++;
      waitRecv(r0 + 3, 20);
      idle(10);
      checkVal(CHK_W'(recvCount), CHK_W'(r0 + 3), "issued after one credit");
      creditReq++;
      waitRecv(r0 + 4, 20);
      idle(5);
      // a surplus credit on top of the full window must be absorbed
      creditReq += elinkCanPkg::CREDIT_INIT + 1;
      idle(6);
      reportTest("credit back-pressure", e0);
   endtask

   task automatic testOverflow();
      int e0;
      int r0;
      e0 = errs;
      autoCredit = 1'b0;
      r0 = recvCount;
      // two issue, four wait, the seventh finds the FIFO full
      for (int f = 0; f < 7; f++)
      begin
         fillFrame();
         sendFrame(0, f < 6);
      end
      idle(20);
      checkVal(CHK_W'(recvCount), CHK_W'(r0 + 2), "issued before overflow credits");
      checkVal(CHK_W'(dropCount), CHK_W'(1), "dropCount");
      creditReq += 4;
      waitRecv(r0 + 6, 40);
      idle(10);
      checkVal(CHK_W'(recvCount), CHK_W'(r0 + 6), "issued after overflow credits");
      checkVal(CHK_W'(expQ.size()), CHK_W'(0), "held messages still expected");
      creditReq += elinkCanPkg::CREDIT_INIT;
      autoCredit = 1'b1;
      idle(6);
      reportTest("overflow", e0);
   endtask

   initial
   begin
      void'($urandom(31553));
      rst = 1'b0;
      rxByte = '0;
      creditReturn = 1'b0;
      errs = 0;
      checks = 0;
      recvCount = 0;
      cycles = 0;
      creditReq = 0;
      creditSent = 0;
      autoCredit = 1'b1;
      fork
         watchdog();
         runMonitor();
         driveCredits();
      join_none
      repeat (RESET_CYC) @(posedge clk);
      rst <= 1'b1;
      idle(4);
      testSingleFrame();
      testMalformed();
      testRandomGaps();
      testBackPressure();
      testOverflow();
      if (expQ.size() != 0)
      begin
         $display("%0d expected messages never arrived", expQ.size());
         errs++;
      end
      $display("checks %0d, errors %0d, messages %0d", checks, errs, recvCount);
      if (errs == 0)
      begin
         $display("TB PASSED");
      end
      else
      begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
verilog/elinkCanPkg.sv
verilog/elinkFrameRx.sv
verilog/canMsgBuffer.sv
verilog/canMsgQueue.sv
verilog/elinkCanTop.sv
verification/elinkCan_properties.sv
verification/tbElinkCan.sv

//--- run.sh
#!/bin/sh
# build and run the elink to CAN testbench with Verilator
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
   --top-module tbElinkCan \
   -f src.f \
   --Mdir "$OBJ_DIR" \
   -o simElinkCan
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

"./$OBJ_DIR/simElinkCan" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1
